// ==== verilog.f ====
+incdir+include
hw/lsq_pkg.sv
hw/store_dispatch.sv
hw/store_rs_entry.sv
hw/store_issue_ctrl.sv
hw/store_exec.sv
hw/store_lsq_top.sv
testbench/tb_store_lsq.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the store LSQ testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_store_lsq \
    -Mdir obj_dir -o sim_store_lsq
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_store_lsq > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0

// ==== testbench/tb_store_lsq.sv ====
`include "lsq_params.svh"

module tb_store_lsq;
    import lsq_pkg::*;

    logic                       clk;
    logic                       arst_n;
    logic                       flush;
    logic                       store_valid;
    store_req_t                 store_req;
    logic                       store_ready;
    tag_t                       store_tag;
    cdb_packet_t                cdb [`LSQ_PIPE_WIDTH];
    tag_t                       commit_tags [`LSQ_PIPE_WIDTH];
    logic [`LSQ_PIPE_WIDTH-1:0] commit_vals;
    logic                       mem_stall;
    logic                       mem_req_valid;
    mem_req_t                   mem_req;

    // Reference model state
    mem_req_t exp_q [$];
    mem_req_t exp_head;
    logic     exp_pending;
    tag_t     exp_tag;
    logic     commit_seen;
    logic     in_flight;
    logic     check_failed;
    string    test_name;

    store_lsq_top DUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .store_valid   (store_valid),
        .store_req     (store_req),
        .store_ready   (store_ready),
        .store_tag     (store_tag),
        .cdb           (cdb),
        .commit_tags   (commit_tags),
        .commit_vals   (commit_vals),
        .mem_stall     (mem_stall),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        check_failed = 1'b1;
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [127:0] expv,
                                   input logic [127:0] actv);
        $display("error %s: %s expected %0h actual %0h", test_name, what, expv, actv);
        abort_run();
    endtask

    // Oldest expected write for the assertions
    task automatic refresh_head();
        exp_pending = (exp_q.size() != 0);
        exp_head    = '0;
        if (exp_pending) begin
            exp_head = exp_q[0];
        end
    endtask

    write_matches: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid |-> (exp_pending && (mem_req == exp_head)))
        else report_mismatch("mem_req", 128'({exp_pending, exp_head}),
                             128'({mem_req_valid, mem_req}));

    write_after_commit: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid |-> commit_seen)
        else begin
            $display("error %s: memory write issued before its commit was seen", test_name);
            abort_run();
        end

    stall_blocks_write: assert property (@(posedge clk) disable iff (!arst_n)
        mem_stall |=> !mem_req_valid)
        else begin
            $display("error %s: memory write issued while mem_stall was high", test_name);
            abort_run();
        end

    busy_not_ready: assert property (@(posedge clk) disable iff (!arst_n)
        in_flight |-> !store_ready)
        else report_mismatch("store_ready", 128'(0), 128'(store_ready));

    tag_sequence: assert property (@(posedge clk) disable iff (!arst_n)
        (store_valid && store_ready) |-> (store_tag == exp_tag))
        else report_mismatch("store_tag", 128'(exp_tag), 128'(store_tag));

    flush_frees: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> store_ready)
        else report_mismatch("store_ready after flush", 128'(1), 128'(store_ready));

    function automatic operand_t make_operand(input logic ready, input word_t val,
                                              input tag_t wtag);
        operand_t op;
        op       = '0;
        op.ready = ready;
        if (ready) begin
            op.opnd.value = val;
        end else begin
            op.opnd.waiting.tag = wtag;
        end
        return op;
    endfunction

    task automatic clear_bus();
        for (int i = 0; i < `LSQ_PIPE_WIDTH; i++) begin
            cdb[i] = '0;
        end
    endtask

    task automatic drive_bus(input int port, input tag_t ptag, input word_t val);
        cdb[port].valid  = 1'b1;
        cdb[port].tag    = ptag;
        cdb[port].result = val;
    endtask

    // One-cycle result on a random port
    task automatic broadcast(input tag_t ptag, input word_t val);
        drive_bus($urandom_range(0, `LSQ_PIPE_WIDTH - 1), ptag, val);
        @(negedge clk);
        clear_bus();
    endtask

    task automatic pulse_commit(input tag_t ctag, input bit matching);
        int p;
        p              = $urandom_range(0, `LSQ_PIPE_WIDTH - 1);
        commit_vals[p] = 1'b1;
        commit_tags[p] = ctag;
        if (matching) begin
            commit_seen = 1'b1;
        end
        @(negedge clk);
        commit_vals = '0;
    endtask

    // Operand modes are 0 ready, 1 woken later and 2 same-cycle bypass
    task automatic accept_store(input int base_mode, input int data_mode, output tag_t tag,
                                output mem_req_t w, output word_t base_val,
                                output tag_t btag, output tag_t dtag);
        store_req_t req;
        logic [1:0] sz;
        int         n;
        int         pb;
        base_val = $urandom();
        w.data   = $urandom();
        sz       = 2'($urandom_range(0, 2));
        w.size   = size_t'(sz);
        btag     = tag_t'($urandom());
        dtag     = btag ^ tag_t'(1);
        req.imm  = $urandom();
        req.size = w.size;
        req.base = make_operand(base_mode == 0, base_val, btag);
        req.data = make_operand(data_mode == 0, w.data, dtag);
        w.addr   = base_val + req.imm;
        n = 0;
        while (!store_ready) begin
            if (n == 40) begin
                $display("timeout: store_ready never returned high in %s", test_name);
                abort_run();
            end else begin
                @(negedge clk);
                n++;
            end
        end
        pb          = $urandom_range(0, `LSQ_PIPE_WIDTH - 1);
        store_valid = 1'b1;
        store_req   = req;
        if (base_mode == 2) begin
            drive_bus(pb, btag, base_val);
        end
        if (data_mode == 2) begin
            drive_bus((pb + 1) % `LSQ_PIPE_WIDTH, dtag, w.data);
        end
        tag = exp_tag;
        @(negedge clk);
        store_valid = 1'b0;
        clear_bus();
        exp_tag   = exp_tag + tag_t'(1);
        in_flight = 1'b1;
    endtask

    task automatic wait_for_write();
        int n;
        n = 0;
        while (!mem_req_valid) begin
            if (n == 60) begin
                $display("timeout: no memory write appeared in %s", test_name);
                abort_run();
            end else begin
                @(negedge clk);
                n++;
            end
        end
        in_flight = 1'b0;
        // Let the checks sample the pulse before retiring it
        @(negedge clk);
        void'(exp_q.pop_front());
        refresh_head();
        commit_seen = 1'b0;
    endtask

    task automatic run_store(input int base_mode, input int data_mode,
                             input bit early_commit, input int stall_cycles);
        tag_t     tag;
        tag_t     btag;
        tag_t     dtag;
        mem_req_t w;
        word_t    base_val;
        accept_store(base_mode, data_mode, tag, w, base_val, btag, dtag);
        exp_q.push_back(w);
        refresh_head();
        // Commit ahead of the operands is kept as sticky permission
        if (early_commit) begin
            pulse_commit(tag, 1'b1);
        end
        if (base_mode == 1) begin
            repeat ($urandom_range(0, 3)) @(negedge clk);
            broadcast(btag, base_val);
        end
        if (data_mode == 1) begin
            repeat ($urandom_range(0, 3)) @(negedge clk);
            broadcast(dtag, w.data);
        end
        mem_stall = (stall_cycles > 0);
        if (!early_commit) begin
            pulse_commit(~tag, 1'b0);
            // Entry reaches WAIT_COMMIT with only a foreign commit seen
            repeat ($urandom_range(3, 5)) @(negedge clk);
            pulse_commit(tag, 1'b1);
        end
        repeat (stall_cycles) @(negedge clk);
        mem_stall = 1'b0;
        wait_for_write();
    endtask

    task automatic run_flushed_store(input int base_mode);
        tag_t     tag;
        tag_t     btag;
        tag_t     dtag;
        mem_req_t w;
        word_t    base_val;
        accept_store(base_mode, 0, tag, w, base_val, btag, dtag);
        repeat ($urandom_range(0, 3)) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush     = 1'b0;
        in_flight = 1'b0;
        // Late commit for the dropped store must not reach memory
        pulse_commit(tag, 1'b0);
        repeat (8) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'ha69c_f8dd));
        clk          = 1'b0;
        arst_n       = 1'b0;
        flush        = 1'b0;
        store_valid  = 1'b0;
        store_req    = '0;
        mem_stall    = 1'b0;
        commit_vals  = '0;
        for (int i = 0; i < `LSQ_PIPE_WIDTH; i++) begin
            commit_tags[i] = '0;
        end
        clear_bus();
        exp_tag      = '0;
        commit_seen  = 1'b0;
        in_flight    = 1'b0;
        check_failed = 1'b0;
        test_name    = "reset";
        refresh_head();
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        test_name = "ready_operands";
        repeat (12) run_store(0, 0, 1'b0, 0);
        test_name = "bus_wakeup";
        repeat (8) run_store($urandom_range(1, 2), $urandom_range(0, 2), 1'b0, 0);
        test_name = "sticky_commit";
        repeat (4) run_store(1, 1, 1'b1, 0);
        test_name = "mem_stall";
        repeat (5) run_store($urandom_range(0, 1), 0, 1'b0, $urandom_range(1, 6));
        test_name = "flush";
        repeat (4) run_flushed_store($urandom_range(0, 1));
        test_name = "after_flush";
        repeat (2) run_store(0, 0, 1'b0, 0);

        if (!check_failed) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// ==== hw/store_lsq_top.sv ====
`include "lsq_params.svh"

module store_lsq_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic                       store_valid,
    input  lsq_pkg::store_req_t        store_req,
    output logic                       store_ready,
    output lsq_pkg::tag_t              store_tag,
    input  lsq_pkg::cdb_packet_t       cdb [`LSQ_PIPE_WIDTH],
    input  lsq_pkg::tag_t              commit_tags [`LSQ_PIPE_WIDTH],
    input  logic [`LSQ_PIPE_WIDTH-1:0] commit_vals,
    input  logic                       mem_stall,
    output logic                       mem_req_valid,
    output lsq_pkg::mem_req_t          mem_req
);
    import lsq_pkg::*;

    store_entry_t disp_entry;
    store_entry_t entry;
    agu_result_t  agu_result;
    logic         rs_we;
    logic         rs_free;
    logic         entry_valid;
    logic         regs_ready;
    logic         addr_written;
    logic         agu_req_valid;
    logic         issue;
    logic         release_entry;

    // No new store during a flush cycle
    assign rs_free = !entry_valid && !flush;

    store_dispatch u_dispatch (
        .clk         (clk),
        .arst_n      (arst_n),
        .store_valid (store_valid),
        .store_req   (store_req),
        .cdb         (cdb),
        .rs_free     (rs_free),
        .store_ready (store_ready),
        .store_tag   (store_tag),
        .rs_we       (rs_we),
        .rs_entry    (disp_entry)
    );

    store_rs_entry u_rs_entry (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .rs_we         (rs_we),
        .rs_entry      (disp_entry),
        .cdb           (cdb),
        .agu_result    (agu_result),
        .release_entry (release_entry),
        .entry         (entry),
        .entry_valid   (entry_valid),
        .regs_ready    (regs_ready),
        .addr_written  (addr_written)
    );

    store_issue_ctrl u_issue_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .entry_valid   (entry_valid),
        .regs_ready    (regs_ready),
        .addr_written  (addr_written),
        .entry_tag     (entry.tag),
        .commit_tags   (commit_tags),
        .commit_vals   (commit_vals),
        .mem_stall     (mem_stall),
        .agu_req_valid (agu_req_valid),
        .issue         (issue),
        .release_entry (release_entry)
    );

    store_exec u_exec (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .agu_req_valid (agu_req_valid),
        .entry         (entry),
        .issue         (issue),
        .agu_result    (agu_result),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req)
    );

endmodule

// ==== hw/store_exec.sv ====
module store_exec (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  agu_req_valid,
    input  lsq_pkg::store_entry_t entry,
    input  logic                  issue,
    output lsq_pkg::agu_result_t  agu_result,
    output logic                  mem_req_valid,
    output lsq_pkg::mem_req_t     mem_req
);
    import lsq_pkg::*;

    agu_req_t agu_req;
    logic     agu_valid_q;
    tag_t     agu_tag_q;
    word_t    agu_addr_q;

    // Request fields straight from the held entry
    assign agu_req.tag  = entry.tag;
    assign agu_req.base = entry.base.opnd.value;
    assign agu_req.imm  = entry.imm;

    // Result strobe, dropped if a flush hits while in flight
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            agu_valid_q <= 1'b0;
        end else begin
            agu_valid_q <= agu_req_valid && !flush;
        end
    end

    // One-cycle address adder
    always_ff @(posedge clk) begin
        if (agu_req_valid) begin
            agu_tag_q  <= agu_req.tag;
            agu_addr_q <= agu_req.base + agu_req.imm;
        end
    end

    assign agu_result.valid = agu_valid_q;
    assign agu_result.tag   = agu_tag_q;
    assign agu_result.addr  = agu_addr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= issue && !flush;
        end
    end

    // Write request payload
    always_ff @(posedge clk) begin
        if (issue) begin
            mem_req.addr <= entry.addr;
            mem_req.data <= entry.data.opnd.value;
            mem_req.size <= entry.size;
        end
    end

endmodule

// ==== hw/store_issue_ctrl.sv ====
`include "lsq_params.svh"

module store_issue_ctrl (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic                       entry_valid,
    input  logic                       regs_ready,
    input  logic                       addr_written,
    input  lsq_pkg::tag_t              entry_tag,
    input  lsq_pkg::tag_t              commit_tags [`LSQ_PIPE_WIDTH],
    input  logic [`LSQ_PIPE_WIDTH-1:0] commit_vals,
    input  logic                       mem_stall,
    output logic                       agu_req_valid,
    output logic                       issue,
    output logic                       release_entry
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_REG,
        WAIT_AGU,
        WAIT_COMMIT
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   commit_hit;
    logic   perm_q;
    logic   perm_now;

    // Commit may come on either port
    always_comb begin
        commit_hit = 1'b0;
        for (int i = 0; i < `LSQ_PIPE_WIDTH; i++) begin
            if (commit_vals[i] && (commit_tags[i] == entry_tag)) begin
                commit_hit = 1'b1;
            end
        end
    end

    // Permission sticks until the entry leaves
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            perm_q <= 1'b0;
        end else if (flush || release_entry) begin
            perm_q <= 1'b0;
        end else if (entry_valid && commit_hit) begin
            perm_q <= 1'b1;
        end
    end

    // A hit this cycle counts right away
    assign perm_now = perm_q || (entry_valid && commit_hit);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
        end else if (flush) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d       = state_q;
        agu_req_valid = 1'b0;
        issue         = 1'b0;
        case (state_q)
            IDLE: begin
                // Ready operands skip straight to the adder
                if (entry_valid) begin
                    if (regs_ready) begin
                        agu_req_valid = 1'b1;
                        state_d       = WAIT_AGU;
                    end else begin
                        state_d = WAIT_REG;
                    end
                end
            end
            WAIT_REG: begin
                if (regs_ready) begin
                    agu_req_valid = 1'b1;
                    state_d       = WAIT_AGU;
                end
            end
            WAIT_AGU: begin
                if (addr_written) begin
                    state_d = WAIT_COMMIT;
                end
            end
            WAIT_COMMIT: begin
                // Stall holds us here with permission kept
                if (perm_now && !mem_stall) begin
                    issue   = 1'b1;
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign release_entry = issue;

endmodule

// ==== hw/store_rs_entry.sv ====
`include "lsq_params.svh"

module store_rs_entry (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  rs_we,
    input  lsq_pkg::store_entry_t rs_entry,
    input  lsq_pkg::cdb_packet_t  cdb [`LSQ_PIPE_WIDTH],
    input  lsq_pkg::agu_result_t  agu_result,
    input  logic                  release_entry,
    output lsq_pkg::store_entry_t entry,
    output logic                  entry_valid,
    output logic                  regs_ready,
    output logic                  addr_written
);
    import lsq_pkg::*;

    store_entry_t entry_q;
    logic         valid_q;
    operand_t     base_woken;
    operand_t     data_woken;

    // Wakeup from either result-bus port
    assign base_woken = wake_operand(entry_q.base, cdb);
    assign data_woken = wake_operand(entry_q.data, cdb);

    // Address result belongs to us only if the tag lines up
    assign addr_written = valid_q && agu_result.valid && (agu_result.tag == entry_q.tag);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (flush || release_entry) begin
            valid_q <= 1'b0;
        end else if (rs_we) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rs_we) begin
            entry_q <= rs_entry;
        end else begin
            entry_q.base <= base_woken;
            entry_q.data <= data_woken;
            if (addr_written) begin
                entry_q.addr      <= agu_result.addr;
                entry_q.addr_done <= 1'b1;
            end
        end
    end

    assign entry       = entry_q;
    assign entry_valid = valid_q;

    // Both registers known, address can be computed
    assign regs_ready = valid_q && entry_q.base.ready && entry_q.data.ready;

endmodule

// ==== hw/store_dispatch.sv ====
`include "lsq_params.svh"

module store_dispatch (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  store_valid,
    input  lsq_pkg::store_req_t   store_req,
    input  lsq_pkg::cdb_packet_t  cdb [`LSQ_PIPE_WIDTH],
    input  logic                  rs_free,
    output logic                  store_ready,
    output lsq_pkg::tag_t         store_tag,
    output logic                  rs_we,
    output lsq_pkg::store_entry_t rs_entry
);
    import lsq_pkg::*;

    tag_t tag_q;

    // One free slot means we can take a store
    assign store_ready = rs_free;
    assign rs_we       = store_valid && rs_free;

    // Tag handed out in the accepting cycle
    assign store_tag = tag_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_q <= '0;
        end else if (rs_we) begin
            // Wraps around on overflow
            tag_q <= tag_q + 1'b1;
        end
    end

    // Build the entry, catching results broadcast in this same cycle
    always_comb begin
        rs_entry           = '0;
        rs_entry.tag       = tag_q;
        rs_entry.base      = wake_operand(store_req.base, cdb);
        rs_entry.data      = wake_operand(store_req.data, cdb);
        rs_entry.imm       = store_req.imm;
        rs_entry.size      = store_req.size;
        // Address comes later from the adder
        rs_entry.addr_done = 1'b0;
        rs_entry.addr      = '0;
    end

endmodule

// ==== hw/lsq_pkg.sv ====
`include "lsq_params.svh"

package lsq_pkg;

    typedef logic [`LSQ_TAG_WIDTH-1:0] tag_t;
    typedef logic [`LSQ_XLEN-1:0]      word_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_t;

    // Producer tag sits in the low bits of a waiting operand
    typedef struct packed {
        logic [`LSQ_XLEN-`LSQ_TAG_WIDTH-1:0] pad;
        tag_t                               tag;
    } wait_tag_t;

    // Value once ready, waiting tag before that
    typedef union packed {
        word_t     value;
        wait_tag_t waiting;
    } operand_u;

    typedef struct packed {
        logic     ready;
        operand_u opnd;
    } operand_t;

    typedef struct packed {
        operand_t base;
        operand_t data;
        word_t    imm;
        size_t    size;
    } store_req_t;

    typedef struct packed {
        tag_t     tag;
        operand_t base;
        operand_t data;
        word_t    imm;
        size_t    size;
        logic     addr_done;
        word_t    addr;
    } store_entry_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t result;
    } cdb_packet_t;

    typedef struct packed {
        word_t addr;
        word_t data;
        size_t size;
    } mem_req_t;

    typedef struct packed {
        tag_t  tag;
        word_t base;
        word_t imm;
    } agu_req_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t addr;
    } agu_result_t;

    // Capture a result for a waiting operand from any matching bus port
    function automatic operand_t wake_operand(operand_t op,
                                              cdb_packet_t cdb [`LSQ_PIPE_WIDTH]);
        operand_t res;
        res = op;
        for (int i = 0; i < `LSQ_PIPE_WIDTH; i++) begin
            if (!res.ready && cdb[i].valid && (cdb[i].tag == res.opnd.waiting.tag)) begin
                res.ready      = 1'b1;
                res.opnd.value = cdb[i].result;
            end
        end
        // Still waiting, keep the upper bits clean
        if (!res.ready) begin
            res.opnd.waiting.pad = '0;
        end
        return res;
    endfunction

endpackage

// ==== include/lsq_params.svh ====
`ifndef LSQ_PARAMS_SVH
`define LSQ_PARAMS_SVH

// Data and address width
`define LSQ_XLEN 32

// Width of store tags and producer tags
`define LSQ_TAG_WIDTH 5

// Number of result-bus ports and commit ports
`define LSQ_PIPE_WIDTH 2

`endif
